//--- common/soc_pkg.sv
package soc_pkg;

    // ##################################################
    // widths and plain vector types
    // ##################################################
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  sel_t;
    typedef logic [3:0]  slot_t;      // addr[31:28]
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] baud_t;      // clocks per bit

    localparam int TCM_ADDR_WIDTH = 10;
    typedef logic [TCM_ADDR_WIDTH-1:0] word_idx_t;

    localparam int RESET_FILTER_LENGTH = 4;

    // ##################################################
    // address map
    // ##################################################
    localparam int    SLOT_COUNT = 16;
    localparam slot_t SLOT_TCM   = 4'd0;
    localparam slot_t SLOT_UART  = 4'd1;
    localparam slot_t SLOT_TIMER = 4'd2;

    // uart register offsets, in words
    localparam word_idx_t UART_REG_DATA   = 10'd0;
    localparam word_idx_t UART_REG_STATUS = 10'd1;
    localparam word_idx_t UART_REG_CTRL   = 10'd2;
    localparam word_idx_t UART_REG_BAUD   = 10'd4;

    localparam baud_t BAUD_RESET = 16'd16;

    // ##################################################
    // bus structs
    // ##################################################
    typedef struct packed {
        addr_t addr;
        data_t wdata;
        sel_t  sel;
        logic  we;
        logic  stb;
    } bus_req_t;

    typedef struct packed {
        data_t rdata;
        logic  ack;
    } bus_rsp_t;

    // request as seen by one target behind the fabric
    typedef struct packed {
        word_idx_t idx;
        data_t     wdata;
        sel_t      sel;
        logic      we;
        logic      stb;
    } tgt_req_t;

endpackage

//--- source/reset_filter.sv
`timescale 1ns/1ps

module reset_filter
(
    input  logic    w_clk,
    input  logic    i_reset,
    output logic    o_reset
);

    import soc_pkg::*;

    logic [RESET_FILTER_LENGTH-1:0] stages;

    always_ff @(posedge w_clk)
    begin
        stages <= {stages[RESET_FILTER_LENGTH-2:0], i_reset};

        // output moves only once every stage agrees
        if (&stages)
            o_reset <= 1'b1;
        else if (~|stages)
            o_reset <= 1'b0;
    end

endmodule

//--- source/bus_fabric.sv
`timescale 1ns/1ps

module bus_fabric
(
    input  logic                w_clk,
    input  logic                i_reset,
    input  soc_pkg::bus_req_t   i_bus_req,
    output soc_pkg::bus_rsp_t   o_bus_rsp,
    output soc_pkg::tgt_req_t   o_tcm_req,
    input  soc_pkg::data_t      i_tcm_rdata,
    input  logic                i_tcm_ack,
    output soc_pkg::tgt_req_t   o_uart_req,
    input  soc_pkg::data_t      i_uart_rdata,
    input  logic                i_uart_ack
);

    import soc_pkg::*;

    slot_t                  slot;
    logic [SLOT_COUNT-1:0]  slot_hit;     // one-hot decode
    logic                   fwd;
    logic                   in_flight;
    slot_t                  slot_q;
    data_t                  timer;
    data_t                  local_rdata;  // timer and unmapped answers
    logic                   local_ack;
    data_t                  sel_rdata;
    logic                   sel_ack;
    data_t                  rsp_rdata;
    logic                   rsp_ack;

    assign slot     = i_bus_req.addr[31:28];
    assign slot_hit = SLOT_COUNT'(1) << slot;
    assign fwd      = i_bus_req.stb & ~in_flight;   // one strobe per request

    always_comb
    begin
        o_tcm_req.idx   = i_bus_req.addr[TCM_ADDR_WIDTH+1:2];
        o_tcm_req.wdata = i_bus_req.wdata;
        o_tcm_req.sel   = i_bus_req.sel;
        o_tcm_req.we    = i_bus_req.we;
        o_tcm_req.stb   = fwd & slot_hit[SLOT_TCM];
        o_uart_req      = o_tcm_req;
        o_uart_req.stb  = fwd & slot_hit[SLOT_UART];
    end

    // ##################################################
    // free running cycle timer
    // ##################################################
    always_ff @(posedge w_clk)
    begin
        if (i_reset)
            timer <= '0;
        else
            timer <= timer + 32'd1;
    end

    always_ff @(posedge w_clk)
    begin
        if (i_reset)
        begin
            in_flight <= 1'b0;
            local_ack <= 1'b0;
            rsp_ack   <= 1'b0;
        end
        else
        begin
            if (fwd)
                in_flight <= 1'b1;
            else if (!i_bus_req.stb)
                in_flight <= 1'b0;    // master has let go
            local_ack <= fwd & ~slot_hit[SLOT_TCM] & ~slot_hit[SLOT_UART];
            rsp_ack   <= sel_ack & i_bus_req.stb;
        end
    end

    always_ff @(posedge w_clk)
    begin
        if (fwd)
            slot_q <= slot;
        local_rdata <= slot_hit[SLOT_TIMER] ? timer : '0;  // unmapped reads zero
        rsp_rdata   <= sel_rdata;
    end

    always_comb
    begin
        case (slot_q)
            SLOT_TCM:
            begin
                sel_rdata = i_tcm_rdata;
                sel_ack   = i_tcm_ack;
            end
            SLOT_UART:
            begin
                sel_rdata = i_uart_rdata;
                sel_ack   = i_uart_ack;
            end
            default:
            begin
                sel_rdata = local_rdata;
                sel_ack   = local_ack;
            end
        endcase
    end

    always_comb
    begin
        o_bus_rsp.rdata = rsp_rdata;
        o_bus_rsp.ack   = rsp_ack;
    end

endmodule

//--- source/tcm.sv
`timescale 1ns/1ps

module tcm
(
    input  logic                w_clk,
    input  soc_pkg::tgt_req_t   i_req,
    output soc_pkg::data_t      o_rdata,
    output logic                o_ack
);

    import soc_pkg::*;

    data_t  mem [2 ** TCM_ADDR_WIDTH];
    sel_t   wr_lanes;

    assign wr_lanes = i_req.sel & {4{i_req.stb & i_req.we}};

    // byte lane writes
    always_ff @(posedge w_clk)
    begin
        for (int lane = 0; lane < 4; lane++)
        begin
            if (wr_lanes[lane])
                mem[i_req.idx][8*lane +: 8] <= i_req.wdata[8*lane +: 8];
        end
    end

    always_ff @(posedge w_clk)
    begin
        o_rdata <= mem[i_req.idx];    // old word on a write
        o_ack   <= i_req.stb;
    end

endmodule

//--- uart/uart_tx.sv
`timescale 1ns/1ps

module uart_tx
(
    input  logic                w_clk,
    input  logic                i_reset,
    input  logic                i_start,
    input  soc_pkg::byte_t      i_byte,
    input  soc_pkg::baud_t      i_baud,
    output logic                o_busy,
    output logic                o_tx
);

    import soc_pkg::*;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

    tx_state_t  state;
    baud_t      cnt;
    logic [2:0] bit_cnt;
    logic [2:0] next_bit;
    logic       bit_end;
    byte_t      data_q;

    assign bit_end  = (cnt == i_baud - 16'd1);
    assign next_bit = bit_cnt + 3'd1;
    assign o_busy   = (state != TX_IDLE);    // through end of stop bit

    always_ff @(posedge w_clk)
    begin
        if (i_reset)
        begin
            state   <= TX_IDLE;
            cnt     <= '0;
            bit_cnt <= '0;
            o_tx    <= 1'b1;
        end
        else if (state == TX_IDLE)
        begin
            cnt <= '0;
            if (i_start)
            begin
                state <= TX_START;
                o_tx  <= 1'b0;
            end
        end
        else if (!bit_end)
            cnt <= cnt + 16'd1;
        else
        begin
            cnt <= '0;
            case (state)
                TX_START:
                begin
                    state   <= TX_DATA;
                    bit_cnt <= '0;
                    o_tx    <= data_q[0];  // lsb first
                end
                TX_DATA:
                begin
                    bit_cnt <= next_bit;
                    if (bit_cnt == 3'd7)
                    begin
                        state <= TX_STOP;
                        o_tx  <= 1'b1;
                    end
                    else
                        o_tx <= data_q[next_bit];
                end
                default:
                    state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge w_clk)
    begin
        if (state == TX_IDLE && i_start)
            data_q <= i_byte;
    end

endmodule

//--- uart/uart_rx.sv
`timescale 1ns/1ps

module uart_rx
(
    input  logic                w_clk,
    input  logic                i_reset,
    input  logic                i_rx,
    input  soc_pkg::baud_t      i_baud,
    output logic                o_valid,
    output soc_pkg::byte_t      o_byte
);

    import soc_pkg::*;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t  state;
    logic       rx_meta;
    logic       rx_sync;
    logic       rx_last;
    baud_t      cnt;
    logic [2:0] bit_cnt;
    logic       half_end;
    logic       bit_end;
    byte_t      shift;

    assign half_end = (cnt == (i_baud >> 1) - 16'd1);
    assign bit_end  = (cnt == i_baud - 16'd1);
    assign o_byte   = shift;

    // two flop synchronizer plus one for edge detect
    always_ff @(posedge w_clk)
    begin
        if (i_reset)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_last <= 1'b1;
        end
        else
        begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
            rx_last <= rx_sync;
        end
    end

    always_ff @(posedge w_clk)
    begin
        if (i_reset)
        begin
            state   <= RX_IDLE;
            cnt     <= '0;
            bit_cnt <= '0;
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= 1'b0;
            cnt     <= cnt + 16'd1;
            case (state)
                RX_IDLE:
                begin
                    cnt <= '0;
                    if (rx_last && !rx_sync)
                        state <= RX_START;    // falling edge
                end
                RX_START:
                    if (half_end)
                    begin
                        cnt     <= '0;
                        bit_cnt <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;  // glitch check
                    end
                RX_DATA:
                    if (bit_end)
                    begin
                        cnt     <= '0;
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7)
                            state <= RX_STOP;
                    end
                default:
                    if (bit_end)
                    begin
                        state   <= RX_IDLE;
                        o_valid <= rx_sync;   // bad stop bit drops the frame
                    end
            endcase
        end
    end

    always_ff @(posedge w_clk)
    begin
        if (state == RX_DATA && bit_end)
            shift <= {rx_sync, shift[7:1]};
    end

endmodule

//--- uart/uart_regs.sv
`timescale 1ns/1ps

module uart_regs
(
    input  logic                w_clk,
    input  logic                i_reset,
    input  soc_pkg::tgt_req_t   i_req,
    output soc_pkg::data_t      o_rdata,
    output logic                o_ack,
    output logic                o_tx_start,
    output soc_pkg::byte_t      o_tx_byte,
    output soc_pkg::baud_t      o_baud,
    input  logic                i_tx_busy,
    input  logic                i_rx_valid,
    input  soc_pkg::byte_t      i_rx_byte
);

    import soc_pkg::*;

    logic   wr;
    logic   rd;
    logic   data_wr;
    logic   tx_busy_any;
    logic   rx_taken;
    logic   rx_accept;
    logic   rx_en;
    logic   rx_full;
    logic   tx_ovr;
    logic   rx_ovr;
    byte_t  rx_data;

    assign wr          = i_req.stb & i_req.we;
    assign rd          = i_req.stb & ~i_req.we;
    assign data_wr     = wr & i_req.sel[0] & (i_req.idx == UART_REG_DATA);
    assign tx_busy_any = i_tx_busy | o_tx_start;  // start pulse not yet seen by tx
    assign rx_taken    = rd & (i_req.idx == UART_REG_DATA);
    assign rx_accept   = i_rx_valid & rx_en & (~rx_full | rx_taken);

    // ##################################################
    // control and status
    // ##################################################
    always_ff @(posedge w_clk)
    begin
        if (i_reset)
        begin
            o_ack      <= 1'b0;
            o_tx_start <= 1'b0;
            o_baud     <= BAUD_RESET;
            rx_en      <= 1'b0;
            rx_full    <= 1'b0;
            tx_ovr     <= 1'b0;
            rx_ovr     <= 1'b0;
        end
        else
        begin
            o_ack      <= i_req.stb;
            o_tx_start <= data_wr & ~tx_busy_any;

            if (data_wr && tx_busy_any)
                tx_ovr <= 1'b1;       // byte dropped

            if (wr && i_req.sel[0] && i_req.idx == UART_REG_STATUS)
            begin
                if (i_req.wdata[2])
                    tx_ovr <= 1'b0;
                if (i_req.wdata[3])
                    rx_ovr <= 1'b0;
            end

            if (wr && i_req.sel[0] && i_req.idx == UART_REG_CTRL)
                rx_en <= i_req.wdata[0];

            if (wr && i_req.idx == UART_REG_BAUD)
            begin
                if (i_req.sel[0])
                    o_baud[7:0] <= i_req.wdata[7:0];
                if (i_req.sel[1])
                    o_baud[15:8] <= i_req.wdata[15:8];
            end

            if (rx_taken)
                rx_full <= 1'b0;
            if (rx_accept)
                rx_full <= 1'b1;
            else if (i_rx_valid && rx_en)
                rx_ovr <= 1'b1;       // held byte wins
        end
    end

    // ##################################################
    // data and read mux
    // ##################################################
    always_ff @(posedge w_clk)
    begin
        if (data_wr && !tx_busy_any)
            o_tx_byte <= i_req.wdata[7:0];
        if (rx_accept)
            rx_data <= i_rx_byte;

        case (i_req.idx)
            UART_REG_DATA:   o_rdata <= {24'd0, rx_data};
            UART_REG_STATUS: o_rdata <= {28'd0, rx_ovr, tx_ovr, rx_full, tx_busy_any};
            UART_REG_CTRL:   o_rdata <= {31'd0, rx_en};
            UART_REG_BAUD:   o_rdata <= {16'd0, o_baud};
            default:         o_rdata <= '0;
        endcase
    end

endmodule

//--- source/soc_top.sv
`timescale 1ns/1ps

module soc_top
(
    input  logic                w_clk,
    input  logic                i_reset,
    input  soc_pkg::bus_req_t   i_bus_req,
    output soc_pkg::bus_rsp_t   o_bus_rsp,
    input  logic                i_rx,
    output logic                o_tx
);

    import soc_pkg::*;

    logic       w_reset;
    tgt_req_t   w_tcm_req;
    data_t      w_tcm_rdata;
    logic       w_tcm_ack;
    tgt_req_t   w_uart_req;
    data_t      w_uart_rdata;
    logic       w_uart_ack;
    logic       w_tx_start;
    byte_t      w_tx_byte;
    baud_t      w_baud;
    logic       w_tx_busy;
    logic       w_rx_valid;
    byte_t      w_rx_byte;

    reset_filter
    u_reset_filter
    (
        .w_clk          (w_clk),
        .i_reset        (i_reset),
        .o_reset        (w_reset)
    );

    // ##################################################
    // bus fabric and targets
    // ##################################################
    bus_fabric
    u_fabric
    (
        .w_clk          (w_clk),
        .i_reset        (w_reset),
        .i_bus_req      (i_bus_req),
        .o_bus_rsp      (o_bus_rsp),
        .o_tcm_req      (w_tcm_req),
        .i_tcm_rdata    (w_tcm_rdata),
        .i_tcm_ack      (w_tcm_ack),
        .o_uart_req     (w_uart_req),
        .i_uart_rdata   (w_uart_rdata),
        .i_uart_ack     (w_uart_ack)
    );

    tcm
    u_tcm
    (
        .w_clk          (w_clk),
        .i_req          (w_tcm_req),
        .o_rdata        (w_tcm_rdata),
        .o_ack          (w_tcm_ack)
    );

    uart_regs
    u_uart_regs
    (
        .w_clk          (w_clk),
        .i_reset        (w_reset),
        .i_req          (w_uart_req),
        .o_rdata        (w_uart_rdata),
        .o_ack          (w_uart_ack),
        .o_tx_start     (w_tx_start),
        .o_tx_byte      (w_tx_byte),
        .o_baud         (w_baud),
        .i_tx_busy      (w_tx_busy),
        .i_rx_valid     (w_rx_valid),
        .i_rx_byte      (w_rx_byte)
    );

    uart_tx
    u_uart_tx
    (
        .w_clk          (w_clk),
        .i_reset        (w_reset),
        .i_start        (w_tx_start),
        .i_byte         (w_tx_byte),
        .i_baud         (w_baud),
        .o_busy         (w_tx_busy),
        .o_tx           (o_tx)
    );

    uart_rx
    u_uart_rx
    (
        .w_clk          (w_clk),
        .i_reset        (w_reset),
        .i_rx           (i_rx),
        .i_baud         (w_baud),
        .o_valid        (w_rx_valid),
        .o_byte         (w_rx_byte)
    );

endmodule

//--- tb/tb_soc_top.sv
`timescale 1ns/1ps

module tb_soc_top;

    import soc_pkg::*;

    localparam int    ACK_LATENCY   = 2;      // decode register plus target register
    localparam int    ACCESS_CYCLES = 4;      // stb to stb for back to back accesses
    localparam int    ACK_LIMIT     = 16;
    localparam baud_t LOOP_BAUD     = 16'd12;
    localparam int    FRAME_CYCLES  = 10 * int'(LOOP_BAUD);
    localparam int    POLL_LIMIT    = 2 * FRAME_CYCLES / ACCESS_CYCLES;
    // four frames plus about 200 bus accesses, with margin
    localparam int    TIMEOUT_CYCLES = 4000;

    // uart status bits
    localparam int ST_TX_BUSY = 0;
    localparam int ST_RX_FULL = 1;
    localparam int ST_TX_OVR  = 2;
    localparam int ST_RX_OVR  = 3;

    logic       w_clk;
    logic       i_reset;
    bus_req_t   bus_req;
    bus_rsp_t   bus_rsp;
    logic       serial_line;      // o_tx looped back to i_rx
    integer     seed = 18;
    int         errors = 0;
    int         checks = 0;
    int         cycle_count = 0;
    data_t      tcm_model [word_idx_t];

    soc_top
    dut0
    (
        .w_clk      (w_clk),
        .i_reset    (i_reset),
        .i_bus_req  (bus_req),
        .o_bus_rsp  (bus_rsp),
        .i_rx       (serial_line),
        .o_tx       (serial_line)
    );

    initial
    begin
        w_clk = 1'b0;
        forever #50 w_clk = ~w_clk;
    end

    always @(posedge w_clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("checks: %0d, errors: %0d", checks, errors + 1);
            $display("Simulation failed");
            $finish;
        end
    end

    // ##################################################
    // helpers
    // ##################################################
    function automatic data_t rand_word();
        rand_word = $random(seed);
    endfunction

    function automatic addr_t slot_addr(slot_t slot, word_idx_t idx);
        slot_addr = {slot, 16'd0, idx, 2'b00};
    endfunction

    function automatic addr_t uart_addr(word_idx_t reg_idx);
        uart_addr = slot_addr(SLOT_UART, reg_idx);
    endfunction

    // expected word after a write with byte strobes
    function automatic data_t lane_merge(data_t old_word, data_t new_word, sel_t sel);
        data_t merged;
        merged = old_word;
        for (int lane = 0; lane < 4; lane++)
        begin
            if (sel[lane])
                merged[8*lane +: 8] = new_word[8*lane +: 8];
        end
        lane_merge = merged;
    endfunction

    task automatic check_value(input string what, input data_t got, input data_t expected);
        checks++;
        assert (got == expected)
        else
        begin
            errors++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    // ack must come exactly ACK_LATENCY cycles after stb
    task automatic bus_access(input addr_t addr, input data_t wdata, input sel_t sel,
                              input logic we, output data_t rdata);
        bus_req_t req;
        int       wait_cycles;
        req.addr  = addr;
        req.wdata = wdata;
        req.sel   = sel;
        req.we    = we;
        req.stb   = 1'b1;
        wait_cycles = 0;
        @(posedge w_clk);
        bus_req <= req;
        @(negedge w_clk);
        while (!bus_rsp.ack && wait_cycles < ACK_LIMIT)
        begin
            wait_cycles++;
            @(negedge w_clk);
        end
        rdata = bus_rsp.rdata;
        checks++;
        assert (bus_rsp.ack)
        else
        begin
            errors++;
            $display("no acknowledge within %0d cycles for access to %h", ACK_LIMIT, addr);
        end
        check_value($sformatf("ack latency at %h", addr), data_t'(wait_cycles),
                    data_t'(ACK_LATENCY));
        @(posedge w_clk);
        bus_req <= '0;
        @(negedge w_clk);
        check_value("ack one cycle later", data_t'(bus_rsp.ack), 32'd0);
    endtask

    task automatic bus_write(input addr_t addr, input data_t wdata, input sel_t sel);
        data_t unused;
        bus_access(addr, wdata, sel, 1'b1, unused);
    endtask

    task automatic bus_read(input addr_t addr, output data_t rdata);
        bus_access(addr, '0, 4'hF, 1'b0, rdata);
    endtask

    task automatic wait_status(input int bit_pos, input logic level);
        data_t status;
        int    polls;
        polls = 0;
        bus_read(uart_addr(UART_REG_STATUS), status);
        while (status[bit_pos] != level && polls < POLL_LIMIT)
        begin
            polls++;
            bus_read(uart_addr(UART_REG_STATUS), status);
        end
        checks++;
        assert (status[bit_pos] == level)
        else
        begin
            errors++;
            $display("UART status bit %0d never reached %b at %0t", bit_pos, level, $time);
        end
    endtask

    // ##################################################
    // directed tests
    // ##################################################
    task automatic probe_reset_state();
        data_t got;
        @(negedge w_clk);
        check_value("o_tx after reset", data_t'(serial_line), 32'd1);
        check_value("ack after reset", data_t'(bus_rsp.ack), 32'd0);
        bus_read(uart_addr(UART_REG_STATUS), got);
        check_value("UART STATUS after reset", got, 32'd0);
        bus_read(uart_addr(UART_REG_BAUD), got);
        check_value("UART BAUD after reset", got, data_t'(BAUD_RESET));
    endtask

    task automatic exercise_tcm_lanes();
        word_idx_t idx_list [16];
        data_t     word;
        data_t     got;
        sel_t      sel;
        for (int i = 0; i < 16; i++)
        begin
            word = rand_word();
            idx_list[i] = word[TCM_ADDR_WIDTH-1:0];
            word = rand_word();
            bus_write(slot_addr(SLOT_TCM, idx_list[i]), word, 4'hF);
            tcm_model[idx_list[i]] = word;
        end
        for (int i = 0; i < 16; i++)
        begin
            word = rand_word();
            sel  = word[3:0];     // may be zero, then nothing changes
            word = rand_word();
            bus_write(slot_addr(SLOT_TCM, idx_list[i]), word, sel);
            tcm_model[idx_list[i]] = lane_merge(tcm_model[idx_list[i]], word, sel);
        end
        foreach (tcm_model[idx])
        begin
            bus_read(slot_addr(SLOT_TCM, idx), got);
            check_value($sformatf("TCM word %0d", idx), got, tcm_model[idx]);
        end
    endtask

    task automatic measure_timer_and_unmapped();
        data_t     t0;
        data_t     t1;
        data_t     got;
        data_t     keep;
        word_idx_t idx;
        int        gap;
        got = rand_word();
        gap = 5 + int'(got[2:0]);
        bus_read(slot_addr(SLOT_TIMER, '0), t0);
        repeat (gap) @(posedge w_clk);
        bus_read(slot_addr(SLOT_TIMER, '0), t1);
        check_value("timer delta", t1 - t0, data_t'(gap + ACCESS_CYCLES));

        // unmapped slots answer zero and never reach the TCM
        got  = rand_word();
        idx  = got[TCM_ADDR_WIDTH-1:0];
        keep = rand_word();
        bus_write(slot_addr(SLOT_TCM, idx), keep, 4'hF);
        tcm_model[idx] = keep;
        for (int s = 3; s < SLOT_COUNT; s++)
        begin
            bus_write(slot_addr(slot_t'(s), idx), rand_word(), 4'hF);
            bus_read(slot_addr(slot_t'(s), idx), got);
            check_value($sformatf("slot %0d read", s), got, 32'd0);
        end
        bus_read(slot_addr(SLOT_TCM, idx), got);
        check_value("TCM word behind unmapped writes", got, keep);
    endtask

    task automatic run_uart_loopback();
        data_t got;
        byte_t tx_byte;
        got     = rand_word();
        tx_byte = got[7:0];
        bus_write(uart_addr(UART_REG_BAUD), data_t'(LOOP_BAUD), 4'hF);
        bus_read(uart_addr(UART_REG_BAUD), got);
        check_value("UART BAUD after write", got, data_t'(LOOP_BAUD));
        bus_write(uart_addr(UART_REG_CTRL), 32'd1, 4'hF);    // rx enable
        bus_write(uart_addr(UART_REG_DATA), data_t'(tx_byte), 4'hF);
        wait_status(ST_RX_FULL, 1'b1);
        bus_read(uart_addr(UART_REG_DATA), got);
        check_value("looped byte", got, data_t'(tx_byte));
        bus_read(uart_addr(UART_REG_STATUS), got);
        check_value("rx full after DATA read", data_t'(got[ST_RX_FULL]), 32'd0);
    endtask

    task automatic provoke_uart_overruns();
        data_t got;
        byte_t tx_bytes [4];
        for (int i = 0; i < 4; i++)
        begin
            got = rand_word();
            tx_bytes[i] = got[7:0];
        end
        // second write lands while the first frame goes out
        bus_write(uart_addr(UART_REG_DATA), data_t'(tx_bytes[0]), 4'hF);
        bus_write(uart_addr(UART_REG_DATA), data_t'(tx_bytes[1]), 4'hF);
        wait_status(ST_RX_FULL, 1'b1);
        bus_read(uart_addr(UART_REG_STATUS), got);
        check_value("tx overrun flag", data_t'(got[ST_TX_OVR]), 32'd1);
        bus_read(uart_addr(UART_REG_DATA), got);
        check_value("first byte back", got, data_t'(tx_bytes[0]));
        wait_status(ST_TX_BUSY, 1'b0);
        repeat (8) @(posedge w_clk);
        bus_read(uart_addr(UART_REG_STATUS), got);
        check_value("rx full after dropped byte", data_t'(got[ST_RX_FULL]), 32'd0);

        // ##################################################
        // rx overrun from two frames without a read
        // ##################################################
        bus_write(uart_addr(UART_REG_DATA), data_t'(tx_bytes[2]), 4'hF);
        wait_status(ST_TX_BUSY, 1'b0);
        bus_write(uart_addr(UART_REG_DATA), data_t'(tx_bytes[3]), 4'hF);
        wait_status(ST_RX_OVR, 1'b1);
        bus_read(uart_addr(UART_REG_DATA), got);
        check_value("held byte after rx overrun", got, data_t'(tx_bytes[2]));
        bus_write(uart_addr(UART_REG_STATUS), 32'hC, 4'hF);   // clear both overruns
        bus_read(uart_addr(UART_REG_STATUS), got);
        check_value("status flags after clear", got & 32'hE, 32'd0);
    endtask

    initial
    begin
        i_reset <= 1'b1;
        bus_req <= '0;
        repeat (8) @(posedge w_clk);
        i_reset <= 1'b0;
        repeat (RESET_FILTER_LENGTH + 4) @(posedge w_clk);    // internal reset lags
        probe_reset_state();
        exercise_tcm_lanes();
        measure_timer_and_unmapped();
        run_uart_loopback();
        provoke_uart_overruns();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- soc_top.f
common/soc_pkg.sv
source/reset_filter.sv
source/bus_fabric.sv
source/tcm.sv
uart/uart_tx.sv
uart/uart_rx.sv
uart/uart_regs.sv
source/soc_top.sv
tb/tb_soc_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the soc_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_soc_top \
    -f soc_top.f \
    -o sim_tb_soc_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb_soc_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation completed successfully" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
